// File: hdl/wb_bus_macros.svh
////////////////////////////////////////
// wishbone subsystem address map
// target count, page bytes, sizes and
// the team slot id offset
////////////////////////////////////////
`ifndef WB_BUS_MACROS_SVH
`define WB_BUS_MACROS_SVH

// team slots, at most 16 (one nibble of the slot field)
`define WB_NUM_TEAMS 4
// sram + gpio + team slots
`define WB_NUM_TGT (`WB_NUM_TEAMS + 2)

// target index in the strobe / read data vectors
`define WB_TGT_SRAM 0
`define WB_TGT_GPIO 1
`define WB_TGT_TEAM0 2

// top address byte of each region
`define WB_PAGE_TEAM 8'h30
`define WB_PAGE_GPIO 8'h32
`define WB_PAGE_SRAM 8'h33

// sram word address bits, 64 words
`define WB_SRAM_AW 6
// read-only slot id word
`define WB_TEAM_ID_OFS 16'h0010

`endif

// File: hdl/wb_bus_pkg.sv
////////////////////////////////////////
// wishbone subsystem shared types
// decoded view of one bus address
////////////////////////////////////////
`default_nettype none

package wb_bus_pkg;

    // page / slot / offset split of an address
    typedef struct packed {
        // region select, top byte
        logic [7:0]  page;
        // team slot, low nibble used
        logic [7:0]  slot;
        // byte offset inside the target
        logic [15:0] offset;
    } wb_addr_fields_t;

    // same word seen raw or split into fields
    typedef union packed {
        // forwarded unchanged on the target bus
        logic [31:0]     raw;
        // decode view
        wb_addr_fields_t fields;
    } wb_addr_u;

endpackage

`default_nettype wire

// File: hdl/wb_arbiter.sv
////////////////////////////////////////
// wishbone round-robin arbiter
// two managers share one bus, owner is
// locked from grant until it drops cyc
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
    input  logic        CLK,
    input  logic        nRST,
    // manager 0
    input  logic        m0_cyc,
    input  logic        m0_stb,
    input  logic        m0_we,
    input  logic [31:0] m0_adr,
    input  logic [31:0] m0_dat_w,
    input  logic [3:0]  m0_sel,
    output logic        m0_ack,
    output logic [31:0] m0_dat_r,
    // manager 1
    input  logic        m1_cyc,
    input  logic        m1_stb,
    input  logic        m1_we,
    input  logic [31:0] m1_adr,
    input  logic [31:0] m1_dat_w,
    input  logic [3:0]  m1_sel,
    output logic        m1_ack,
    output logic [31:0] m1_dat_r,
    // shared bus toward the decoder
    output logic        s_cyc,
    output logic        s_stb,
    output logic        s_we,
    output logic [31:0] s_adr,
    output logic [31:0] s_dat_w,
    output logic [3:0]  s_sel,
    input  logic        s_ack,
    input  logic [31:0] s_dat_r
);

    // owner id, kept after release as the last granted manager
    logic owner_q;
    logic owner_vld;
    logic owner_cyc;
    logic busy;
    // grant for this cycle
    logic gnt;
    logic gnt_vld;

    assign owner_cyc = owner_q ? m1_cyc : m0_cyc;
    // locked while the owner still holds cyc
    assign busy = owner_vld && owner_cyc;

    always_comb begin
        if (busy) begin
            gnt     = owner_q;
            gnt_vld = 1'b1;
        end else if (m0_cyc && m1_cyc) begin
            // tie, the one not granted last wins
            gnt     = ~owner_q;
            gnt_vld = 1'b1;
        end else begin
            gnt     = m1_cyc;
            gnt_vld = m0_cyc || m1_cyc;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            owner_vld <= 1'b0;
            // so m0 wins the first tie
            owner_q   <= 1'b1;
        end else begin
            owner_vld <= gnt_vld;
            if (gnt_vld) begin
                owner_q <= gnt;
            end
        end
    end

    ////////////////////////////////////////
    // request mux and response routing
    ////////////////////////////////////////
    assign s_cyc   = gnt_vld;
    assign s_stb   = gnt_vld && (gnt ? m1_stb : m0_stb);
    assign s_we    = gnt ? m1_we : m0_we;
    assign s_adr   = gnt ? m1_adr : m0_adr;
    assign s_dat_w = gnt ? m1_dat_w : m0_dat_w;
    assign s_sel   = gnt ? m1_sel : m0_sel;

    // only the owner sees ack and data
    assign m0_ack   = s_ack && gnt_vld && !gnt;
    assign m1_ack   = s_ack && gnt_vld && gnt;
    assign m0_dat_r = (gnt_vld && !gnt) ? s_dat_r : 32'h0;
    assign m1_dat_r = (gnt_vld && gnt) ? s_dat_r : 32'h0;

endmodule

`default_nettype wire

// File: hdl/wb_decoder.sv
////////////////////////////////////////
// wishbone address decoder
// fixed two-cycle access: decode cycle
// strobes the target and latches data,
// next cycle returns ack
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "wb_bus_macros.svh"

module wb_decoder (
    input  logic                         CLK,
    input  logic                         nRST,
    // from the arbiter
    input  logic                         cyc,
    input  logic                         stb,
    input  logic                         we,
    input  logic [31:0]                  adr,
    input  logic [31:0]                  dat_w,
    input  logic [3:0]                   sel,
    output logic                         ack,
    output logic [31:0]                  dat_r,
    // to the targets, strobe per target, rest broadcast
    output logic [`WB_NUM_TGT-1:0]       tgt_stb,
    output logic                         tgt_we,
    output logic [31:0]                  tgt_adr,
    output logic [31:0]                  tgt_dat_w,
    output logic [3:0]                   tgt_sel,
    input  logic [32*`WB_NUM_TGT-1:0]    tgt_dat_r
);

    import wb_bus_pkg::*;

    localparam int NUM_TGT = `WB_NUM_TGT;
    // idle + one per target + unmapped
    localparam int ST_W = NUM_TGT + 2;
    localparam logic [ST_W-1:0] ST_IDLE = {{(ST_W-1){1'b0}}, 1'b1};

    wb_addr_u             req;
    logic [NUM_TGT-1:0]   hit;
    logic                 accept;
    logic [31:0]          rd_sel;
    logic [ST_W-1:0]      state;
    logic                 ack_q;
    logic [31:0]          dat_q;

    assign req.raw = adr;

    ////////////////////////////////////////
    // address decode
    ////////////////////////////////////////
    always_comb begin
        hit = '0;
        if (req.fields.page == `WB_PAGE_SRAM) begin
            hit[`WB_TGT_SRAM] = 1'b1;
        end
        if (req.fields.page == `WB_PAGE_GPIO) begin
            hit[`WB_TGT_GPIO] = 1'b1;
        end
        // slots past the team count match nothing
        for (int t = 0; t < `WB_NUM_TEAMS; t++) begin
            if (req.fields.page == `WB_PAGE_TEAM && req.fields.slot[3:0] == t[3:0]) begin
                hit[`WB_TGT_TEAM0 + t] = 1'b1;
            end
        end
    end

    // new request only taken in idle
    assign accept = state[0] && cyc && stb;

    // strobe only in the decode cycle
    assign tgt_stb   = accept ? hit : '0;
    assign tgt_we    = we;
    assign tgt_adr   = req.raw;
    assign tgt_dat_w = dat_w;
    assign tgt_sel   = sel;

    // selected target read data, zero if unmapped
    always_comb begin
        rd_sel = '0;
        for (int t = 0; t < NUM_TGT; t++) begin
            if (hit[t]) begin
                rd_sel = rd_sel | tgt_dat_r[32*t +: 32];
            end
        end
    end

    ////////////////////////////////////////
    // state and ack
    ////////////////////////////////////////
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= ST_IDLE;
            ack_q <= 1'b0;
        end else if (state[0]) begin
            if (accept) begin
                // top bit is the unmapped state
                state <= {~|hit, hit, 1'b0};
                ack_q <= 1'b1;
            end
        end else begin
            // ack cycle, always back to idle
            state <= ST_IDLE;
            ack_q <= 1'b0;
        end
    end

    // read data captured at the decode edge
    always_ff @(posedge CLK) begin
        if (accept) begin
            dat_q <= rd_sel;
        end
    end

    assign ack = ack_q;
    // sram data is only valid one edge after its strobe, pass it live
    assign dat_r = state[1 + `WB_TGT_SRAM] ? tgt_dat_r[32*`WB_TGT_SRAM +: 32] : dat_q;

endmodule

`default_nettype wire

// File: hdl/wb_sram.sv
////////////////////////////////////////
// wishbone sram target
// 64 words, byte writes, registered
// read word on every strobe
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "wb_bus_macros.svh"

module wb_sram (
    input  logic                 CLK,
    input  logic                 stb,
    input  logic                 we,
    input  wb_bus_pkg::wb_addr_u adr,
    input  logic [31:0]          dat_w,
    input  logic [3:0]           sel,
    output logic [31:0]          dat_r
);

    localparam int DEPTH = 1 << `WB_SRAM_AW;

    logic [31:0]             mem [DEPTH];
    logic [`WB_SRAM_AW-1:0]  widx;

    // word index from offset bits 7:2
    assign widx = adr.fields.offset[`WB_SRAM_AW+1:2];

    always_ff @(posedge CLK) begin
        if (stb) begin
            if (we) begin
                // each lane on its own enable
                for (int b = 0; b < 4; b++) begin
                    if (sel[b]) begin
                        mem[widx][8*b +: 8] <= dat_w[8*b +: 8];
                    end
                end
            end
            // old word on a write strobe
            dat_r <= mem[widx];
        end
    end

endmodule

`default_nettype wire

// File: hdl/wb_gpio.sv
////////////////////////////////////////
// wishbone gpio target
// offset 0 output register, offset 4
// synchronized input pins
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module wb_gpio (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 stb,
    input  logic                 we,
    input  wb_bus_pkg::wb_addr_u adr,
    input  logic [31:0]          dat_w,
    input  logic [3:0]           sel,
    input  logic [31:0]          gpio_in,
    output logic [31:0]          dat_r,
    output logic [31:0]          gpio_out
);

    logic [31:0] out_q;
    // two-stage synchronizer
    logic [31:0] in_meta;
    logic [31:0] in_sync;
    logic        sel_out;
    logic        sel_in;

    // word decode, byte bits ignored
    assign sel_out = adr.fields.offset[15:2] == 14'd0;
    assign sel_in  = adr.fields.offset[15:2] == 14'd1;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            out_q <= '0;
        end else if (stb && we && sel_out) begin
            for (int b = 0; b < 4; b++) begin
                if (sel[b]) begin
                    out_q[8*b +: 8] <= dat_w[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= gpio_in;
            in_sync <= in_meta;
        end
    end

    // read mux, other offsets read zero
    assign dat_r = sel_out ? out_q :
                   sel_in  ? in_sync : 32'h0;

    assign gpio_out = out_q;

endmodule

`default_nettype wire

// File: hdl/wb_team_regs.sv
////////////////////////////////////////
// wishbone team slot
// four scratch words and a read-only
// id word carrying the slot number
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "wb_bus_macros.svh"

module wb_team_regs #(
    parameter int SLOT = 0
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 stb,
    input  logic                 we,
    input  wb_bus_pkg::wb_addr_u adr,
    input  logic [31:0]          dat_w,
    input  logic [3:0]           sel,
    output logic [31:0]          dat_r
);

    localparam logic [15:0] ID_OFS  = `WB_TEAM_ID_OFS;
    localparam logic [31:0] ID_WORD = 32'hC0DE_0000 + 32'(SLOT);

    logic [31:0] scratch [4];
    logic        sel_scr;
    logic        sel_id;
    logic [1:0]  ridx;

    // scratch at 0x0..0xC, id word alone
    assign sel_scr = adr.fields.offset[15:4] == 12'd0;
    assign sel_id  = adr.fields.offset[15:2] == ID_OFS[15:2];
    assign ridx    = adr.fields.offset[3:2];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int r = 0; r < 4; r++) begin
                scratch[r] <= '0;
            end
        end else if (stb && we && sel_scr) begin
            for (int b = 0; b < 4; b++) begin
                if (sel[b]) begin
                    scratch[ridx][8*b +: 8] <= dat_w[8*b +: 8];
                end
            end
        end
    end

    // id is constant, writes to it fall through
    assign dat_r = sel_scr ? scratch[ridx] :
                   sel_id  ? ID_WORD : 32'h0;

endmodule

`default_nettype wire

// File: hdl/wb_subsystem_top.sv
////////////////////////////////////////
// wishbone interconnect subsystem
// two managers -> arbiter -> decoder ->
// sram, gpio and the team slots
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "wb_bus_macros.svh"

module wb_subsystem_top (
    input  logic        CLK,
    input  logic        nRST,
    // manager 0
    input  logic        m0_cyc,
    input  logic        m0_stb,
    input  logic        m0_we,
    input  logic [31:0] m0_adr,
    input  logic [31:0] m0_dat_w,
    input  logic [3:0]  m0_sel,
    output logic        m0_ack,
    output logic [31:0] m0_dat_r,
    // manager 1
    input  logic        m1_cyc,
    input  logic        m1_stb,
    input  logic        m1_we,
    input  logic [31:0] m1_adr,
    input  logic [31:0] m1_dat_w,
    input  logic [3:0]  m1_sel,
    output logic        m1_ack,
    output logic [31:0] m1_dat_r,
    // pins
    input  logic [31:0] gpio_in,
    output logic [31:0] gpio_out
);

    // shared bus, arbiter to decoder
    logic        s_cyc;
    logic        s_stb;
    logic        s_we;
    logic [31:0] s_adr;
    logic [31:0] s_dat_w;
    logic [3:0]  s_sel;
    logic        s_ack;
    logic [31:0] s_dat_r;

    // decoder to targets
    logic [`WB_NUM_TGT-1:0]    tgt_stb;
    logic                      tgt_we;
    logic [31:0]               tgt_adr;
    logic [31:0]               tgt_dat_w;
    logic [3:0]                tgt_sel;
    logic [32*`WB_NUM_TGT-1:0] tgt_dat_r;

    wb_arbiter i_arbiter (
        .CLK      (CLK),
        .nRST     (nRST),
        .m0_cyc   (m0_cyc),
        .m0_stb   (m0_stb),
        .m0_we    (m0_we),
        .m0_adr   (m0_adr),
        .m0_dat_w (m0_dat_w),
        .m0_sel   (m0_sel),
        .m0_ack   (m0_ack),
        .m0_dat_r (m0_dat_r),
        .m1_cyc   (m1_cyc),
        .m1_stb   (m1_stb),
        .m1_we    (m1_we),
        .m1_adr   (m1_adr),
        .m1_dat_w (m1_dat_w),
        .m1_sel   (m1_sel),
        .m1_ack   (m1_ack),
        .m1_dat_r (m1_dat_r),
        .s_cyc    (s_cyc),
        .s_stb    (s_stb),
        .s_we     (s_we),
        .s_adr    (s_adr),
        .s_dat_w  (s_dat_w),
        .s_sel    (s_sel),
        .s_ack    (s_ack),
        .s_dat_r  (s_dat_r)
    );

    wb_decoder i_decoder (
        .CLK       (CLK),
        .nRST      (nRST),
        .cyc       (s_cyc),
        .stb       (s_stb),
        .we        (s_we),
        .adr       (s_adr),
        .dat_w     (s_dat_w),
        .sel       (s_sel),
        .ack       (s_ack),
        .dat_r     (s_dat_r),
        .tgt_stb   (tgt_stb),
        .tgt_we    (tgt_we),
        .tgt_adr   (tgt_adr),
        .tgt_dat_w (tgt_dat_w),
        .tgt_sel   (tgt_sel),
        .tgt_dat_r (tgt_dat_r)
    );

    ////////////////////////////////////////
    // targets
    ////////////////////////////////////////
    wb_sram i_sram (
        .CLK   (CLK),
        .stb   (tgt_stb[`WB_TGT_SRAM]),
        .we    (tgt_we),
        .adr   (tgt_adr),
        .dat_w (tgt_dat_w),
        .sel   (tgt_sel),
        .dat_r (tgt_dat_r[32*`WB_TGT_SRAM +: 32])
    );

    wb_gpio i_gpio (
        .CLK      (CLK),
        .nRST     (nRST),
        .stb      (tgt_stb[`WB_TGT_GPIO]),
        .we       (tgt_we),
        .adr      (tgt_adr),
        .dat_w    (tgt_dat_w),
        .sel      (tgt_sel),
        .gpio_in  (gpio_in),
        .dat_r    (tgt_dat_r[32*`WB_TGT_GPIO +: 32]),
        .gpio_out (gpio_out)
    );

    // one slot per team, slot number sets the id word
    for (genvar g = 0; g < `WB_NUM_TEAMS; g++) begin : g_team
        wb_team_regs #(
            .SLOT (g)
        ) i_team_regs (
            .CLK   (CLK),
            .nRST  (nRST),
            .stb   (tgt_stb[`WB_TGT_TEAM0 + g]),
            .we    (tgt_we),
            .adr   (tgt_adr),
            .dat_w (tgt_dat_w),
            .sel   (tgt_sel),
            .dat_r (tgt_dat_r[32*(`WB_TGT_TEAM0 + g) +: 32])
        );
    end

endmodule

`default_nettype wire

// File: verif/tb_wb_model.svh
////////////////////////////////////////
// reference model of the memory map
// sram, gpio output reg, team scratch,
// plus the lfsr random source
////////////////////////////////////////
`ifndef TB_WB_MODEL_SVH
`define TB_WB_MODEL_SVH

`include "wb_bus_macros.svh"

// one lfsr stream per stimulus process
logic [31:0] lfsr_q [3];
logic [31:0] sram_m [64];
logic [31:0] gpio_out_m;
logic [31:0] team_m [16][4];

// galois form, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] rand_bits(input int id, input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_q[id][0]};
        lfsr_q[id] = lfsr_next(lfsr_q[id]);
    end
    return v;
endfunction

// same seed, streams pushed apart by stepping
function automatic void seed_streams(input logic [31:0] seed);
    lfsr_q[0] = seed;
    lfsr_q[1] = seed;
    lfsr_q[2] = seed;
    for (int i = 0; i < 997; i++) begin
        lfsr_q[1] = lfsr_next(lfsr_q[1]);
        lfsr_q[2] = lfsr_next(lfsr_next(lfsr_q[2]));
    end
endfunction

function automatic void model_reset();
    gpio_out_m = '0;
    for (int s = 0; s < 16; s++) begin
        for (int r = 0; r < 4; r++) begin
            team_m[s][r] = '0;
        end
    end
endfunction

// byte lanes with sel set take the new data
function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                            input logic [3:0] sel);
    logic [31:0] r;
    r = old_w;
    for (int b = 0; b < 4; b++) begin
        if (sel[b]) begin
            r[8*b +: 8] = new_w[8*b +: 8];
        end
    end
    return r;
endfunction

function automatic void model_write(input logic [31:0] a, input logic [31:0] d,
                                    input logic [3:0] sel);
    logic [7:0]  page;
    logic [3:0]  slot;
    logic [15:0] ofs;
    page = a[31:24];
    slot = a[19:16];
    ofs  = a[15:0];
    if (page == `WB_PAGE_SRAM) begin
        sram_m[ofs[7:2]] = merge_bytes(sram_m[ofs[7:2]], d, sel);
    end else if (page == `WB_PAGE_GPIO && ofs == 16'h0000) begin
        gpio_out_m = merge_bytes(gpio_out_m, d, sel);
    end else if (page == `WB_PAGE_TEAM && int'(slot) < `WB_NUM_TEAMS && ofs < 16'h0010) begin
        team_m[slot][ofs[3:2]] = merge_bytes(team_m[slot][ofs[3:2]], d, sel);
    end
    // id word, gpio input and unmapped space keep nothing
endfunction

// top bit set when the prediction is exact
function automatic logic [32:0] model_read(input logic [31:0] a, input logic [31:0] gin,
                                           input int gin_age);
    logic [7:0]  page;
    logic [3:0]  slot;
    logic [15:0] ofs;
    page = a[31:24];
    slot = a[19:16];
    ofs  = a[15:0];
    if (page == `WB_PAGE_SRAM) begin
        return {1'b1, sram_m[ofs[7:2]]};
    end
    if (page == `WB_PAGE_GPIO) begin
        if (ofs == 16'h0000) begin
            return {1'b1, gpio_out_m};
        end
        // pins must be steady over both sync stages and the decode edge
        if (ofs == 16'h0004) begin
            return {gin_age >= 3, gin};
        end
        return {1'b1, 32'h0};
    end
    if (page == `WB_PAGE_TEAM && int'(slot) < `WB_NUM_TEAMS) begin
        if (ofs < 16'h0010) begin
            return {1'b1, team_m[slot][ofs[3:2]]};
        end
        if (ofs == `WB_TEAM_ID_OFS) begin
            return {1'b1, 32'hC0DE_0000 + 32'(slot)};
        end
    end
    // invalid slot, other offsets, unmapped page
    return {1'b1, 32'h0};
endfunction

`endif

// File: verif/tb_wb_subsystem.sv
////////////////////////////////////////
// testbench for the wishbone subsystem
// two random managers, memory map model,
// address path monitor and watchdog
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_wb_subsystem;

    import wb_bus_pkg::*;

    `include "tb_wb_model.svh"

    localparam logic [31:0] SEED = 32'h2061_6d6a;
    localparam int N_RANDOM  = 200;
    localparam int N_SOLO    = 40;
    localparam int ACK_LIMIT = 20;
    // sram fill + team first reads + random traffic of both managers
    localparam int N_ACCESS    = 64 + `WB_NUM_TEAMS + 2 * N_RANDOM;
    localparam int WATCHDOG_NS = N_ACCESS * 25 * 20;

    logic        CLK = 1'b0;
    logic        nRST;
    // manager side, index is the manager number
    logic        cyc_d  [2];
    logic        stb_d  [2];
    logic        we_d   [2];
    logic [31:0] adr_d  [2];
    logic [31:0] dat_d  [2];
    logic [3:0]  sel_d  [2];
    logic        ack_w  [2];
    logic [31:0] rdat_w [2];
    logic [31:0] gpio_in;
    logic [31:0] gpio_out;
    // falling edges since gpio_in last changed
    int          gpio_age;
    int          err_data;
    int          err_proto;
    int          err_timeout;

    always #10 CLK = ~CLK;

    wb_subsystem_top i_wb_subsystem_top (
        .CLK      (CLK),
        .nRST     (nRST),
        .m0_cyc   (cyc_d[0]),
        .m0_stb   (stb_d[0]),
        .m0_we    (we_d[0]),
        .m0_adr   (adr_d[0]),
        .m0_dat_w (dat_d[0]),
        .m0_sel   (sel_d[0]),
        .m0_ack   (ack_w[0]),
        .m0_dat_r (rdat_w[0]),
        .m1_cyc   (cyc_d[1]),
        .m1_stb   (stb_d[1]),
        .m1_we    (we_d[1]),
        .m1_adr   (adr_d[1]),
        .m1_dat_w (dat_d[1]),
        .m1_sel   (sel_d[1]),
        .m1_ack   (ack_w[1]),
        .m1_dat_r (rdat_w[1]),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////
    task automatic check_rdata(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %08h actual %08h", $time, name, exp, act);
            err_data++;
        end
    endtask

    task automatic check_gpio_out(input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("** Error at %0t: gpio_out expected %08h actual %08h", $time, exp, act);
            err_data++;
        end
    endtask

    task automatic check_addr_path(input int m, input wb_addr_u exp, input wb_addr_u act);
        if (act.raw !== exp.raw) begin
            $display("** Error at %0t: tgt_adr for m%0d expected %08h actual %08h",
                     $time, m, exp.raw, act.raw);
            err_data++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %b actual %b", $time, name, exp, act);
            err_data++;
        end
    endtask

    ////////////////////////////////////////
    // manager driver
    ////////////////////////////////////////
    // one classic cycle, solo marks a quiet bus with fixed latency
    task automatic do_access(input int m, input logic we, input logic [31:0] adr,
                             input logic [31:0] wd, input logic [3:0] sel, input logic solo);
        int          waited;
        logic        got;
        logic [32:0] pred;
        @(negedge CLK);
        cyc_d[m] = 1'b1;
        stb_d[m] = 1'b1;
        we_d[m]  = we;
        adr_d[m] = adr;
        dat_d[m] = wd;
        sel_d[m] = sel;
        waited   = 0;
        got      = 1'b0;
        // ack and read data are steady at the falling edge
        while (!got && waited < ACK_LIMIT) begin
            @(negedge CLK);
            waited++;
            got = ack_w[m];
        end
        if (!got) begin
            $display("manager %0d got no ack within %0d cycles for address %08h at %0t",
                     m, ACK_LIMIT, adr, $time);
            err_timeout++;
        end else begin
            // stb sampled at one rising edge, ack seen at the next
            if (solo && waited != 1) begin
                $display("** Error at %0t: m%0d_ack expected in stb cycle 2 actual cycle %0d",
                         $time, m, waited + 1);
                err_proto++;
            end
            // ack cycle, the model takes the access here
            if (we) begin
                model_write(adr, wd, sel);
                if (adr[31:24] == `WB_PAGE_GPIO) begin
                    check_gpio_out(gpio_out_m, gpio_out);
                end
            end else begin
                pred = model_read(adr, gpio_in, gpio_age);
                if (pred[32]) begin
                    check_rdata($sformatf("m%0d_dat_r @%08h", m, adr), pred[31:0], rdat_w[m]);
                end
            end
        end
        @(negedge CLK);
        // ack is a single cycle pulse
        if (solo) begin
            check_flag($sformatf("m%0d_ack one cycle later", m), 1'b0, ack_w[m]);
        end
        cyc_d[m] = 1'b0;
        stb_d[m] = 1'b0;
    endtask

    // region mix: sram, gpio, valid slot, invalid slot, unmapped page
    task automatic pick_access(input int m, output logic we, output logic [31:0] adr,
                               output logic [31:0] wd, output logic [3:0] sel);
        logic [7:0]  page;
        logic [3:0]  slot;
        logic [15:0] ofs;
        int          kind;
        int          sub;
        kind = int'(rand_bits(m, 3));
        sub  = int'(rand_bits(m, 3));
        slot = 4'(rand_bits(m, 4));
        page = `WB_PAGE_TEAM;
        // team offsets: scratch words, id word, empty space
        ofs  = sub < 4 ? {12'h000, 2'(sub), 2'b00} :
               sub == 4 ? `WB_TEAM_ID_OFS : 16'h0020 + {6'h00, 8'(rand_bits(m, 8)), 2'b00};
        case (kind)
            0, 1: begin
                page = `WB_PAGE_SRAM;
                ofs  = {8'h00, 6'(rand_bits(m, 6)), 2'b00};
            end
            2: begin
                page = `WB_PAGE_GPIO;
                ofs  = sub < 3 ? 16'h0000 :
                       sub < 6 ? 16'h0004 : 16'h0008 + {12'h000, 2'(sub), 2'b00};
            end
            3, 4, 5: slot = 4'(rand_bits(m, 4) % `WB_NUM_TEAMS);
            6: slot = 4'(`WB_NUM_TEAMS + rand_bits(m, 4) % (16 - `WB_NUM_TEAMS));
            default: begin
                page = 8'(rand_bits(m, 8));
                if (page == `WB_PAGE_TEAM || page == `WB_PAGE_GPIO || page == `WB_PAGE_SRAM) begin
                    page = 8'h31;
                end
                ofs = 16'(rand_bits(m, 16)) & 16'hFFFC;
            end
        endcase
        adr = {page, 4'h0, slot, ofs};
        we  = rand_bits(m, 1) != 0;
        wd  = rand_bits(m, 32);
        sel = 4'(rand_bits(m, 4));
    endtask

    task automatic run_random(input int m, input int n, input logic solo);
        logic        we;
        logic [31:0] adr;
        logic [31:0] wd;
        logic [3:0]  sel;
        for (int i = 0; i < n; i++) begin
            pick_access(m, we, adr, wd, sel);
            do_access(m, we, adr, wd, sel, solo);
            // extra idle cycles after the mandatory low cycle
            repeat (rand_bits(m, 2)) @(negedge CLK);
        end
    endtask

    function automatic void print_counts();
        $display("errors: data %0d, protocol %0d, timeout %0d", err_data, err_proto, err_timeout);
    endfunction

    ////////////////////////////////////////
    // pins, monitor, watchdog
    ////////////////////////////////////////
    // pins settle after every reader of this falling edge
    initial begin : gpio_pins
        gpio_in  <= '0;
        gpio_age <= 0;
        forever begin
            @(negedge CLK);
            if (gpio_age >= 6 && rand_bits(2, 2) == 0) begin
                gpio_in  <= rand_bits(2, 32);
                gpio_age <= 0;
            end else if (gpio_age < 1000) begin
                gpio_age <= gpio_age + 1;
            end
        end
    end

    // ack only under own stb, and the target bus carries the owner's address
    initial begin : bus_monitor
        forever begin
            @(negedge CLK);
            for (int m = 0; m < 2; m++) begin
                if (nRST && ack_w[m]) begin
                    if (!stb_d[m]) begin
                        $display("manager %0d saw ack at %0t without its stb raised", m, $time);
                        err_proto++;
                    end
                    check_addr_path(m, adr_d[m], i_wb_subsystem_top.tgt_adr);
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with the tests still running", WATCHDOG_NS);
        print_counts();
        $display("FAIL: see errors above");
        $finish;
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial begin
        err_data    = 0;
        err_proto   = 0;
        err_timeout = 0;
        nRST        = 1'b0;
        for (int m = 0; m < 2; m++) begin
            cyc_d[m] = 1'b0;
            stb_d[m] = 1'b0;
            we_d[m]  = 1'b0;
            adr_d[m] = '0;
            dat_d[m] = '0;
            sel_d[m] = '0;
        end
        seed_streams(SEED);
        model_reset();
        repeat (3) @(negedge CLK);
        nRST = 1'b1;

        // reset values
        @(negedge CLK);
        check_flag("m0_ack", 1'b0, ack_w[0]);
        check_flag("m1_ack", 1'b0, ack_w[1]);
        check_gpio_out(32'h0, gpio_out);

        // first scratch read of each slot, then fill the sram with known words
        for (int s = 0; s < `WB_NUM_TEAMS; s++) begin
            do_access(0, 1'b0, {`WB_PAGE_TEAM, 4'h0, 4'(s), 16'h0000}, '0, 4'hF, 1'b1);
        end
        for (int i = 0; i < 64; i++) begin
            do_access(0, 1'b1, {`WB_PAGE_SRAM, 16'h0000, 6'(i), 2'b00},
                      rand_bits(0, 32), 4'hF, 1'b1);
        end

        // each manager alone, then both at once
        run_random(0, N_SOLO, 1'b1);
        run_random(1, N_SOLO, 1'b1);
        fork
            run_random(0, N_RANDOM - N_SOLO, 1'b0);
            run_random(1, N_RANDOM - N_SOLO, 1'b0);
        join

        repeat (2) @(negedge CLK);
        print_counts();
        if (err_data + err_proto + err_timeout == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hdl
+incdir+verif
hdl/wb_bus_pkg.sv
hdl/wb_arbiter.sv
hdl/wb_decoder.sv
hdl/wb_sram.sv
hdl/wb_gpio.sv
hdl/wb_team_regs.sv
hdl/wb_subsystem_top.sv
verif/tb_wb_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# build the wishbone subsystem testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
    -f verilog.f \
    --top-module tb_wb_subsystem \
    -o tb_wb_subsystem

out=$(./obj_dir/tb_wb_subsystem)
echo "$out"

# pass only if the testbench printed its pass line
echo "$out" | grep -qx "PASS: all tests"
